//--- Makefile
# Verilator build for the multicycle CPU testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

SOURCES := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/instr_fetch.sv
verilog/operand_resolver.sv
verilog/exec_unit.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
test/tb_cpu.sv

//--- test/tb_cpu.sv
`default_nettype none

`include "cpu_params.svh"

module tb_cpu;

    logic               clk;
    logic               rst_n;
    cpu_pkg::word_t     mem_rdata;
    logic               we;
    cpu_pkg::addr_t     addr;
    cpu_pkg::word_t     data;
    cpu_pkg::word_t     out;
    logic               status;
    cpu_pkg::addr_t     pc;

    cpu_pkg::word_t     mem_arr  [0:63];  // Memory seen by the DUT
    cpu_pkg::word_t     init_img [0:63];  // Image loaded while in reset
    cpu_pkg::word_t     exp_mem  [0:63];  // Expected contents
    logic [31:0]        rng_state;

    cpu_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem    (mem_rdata),
        .we     (we),
        .addr   (addr),
        .data   (data),
        .out    (out),
        .status (status),
        .pc     (pc)
    );

    // Combinational read, write on the clock edge
    assign mem_rdata = mem_arr[addr];

    always @(posedge clk) begin
        if (!rst_n) begin
            mem_arr <= init_img;
        end else if (we) begin
            mem_arr[addr] <= data;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cpu_pkg::operand_t direct_reg(input logic [2:0] r);
        return '{ind: 1'b0, rg: r};
    endfunction

    function automatic cpu_pkg::operand_t indirect_reg(input logic [2:0] r);
        return '{ind: 1'b1, rg: r};
    endfunction

    function automatic cpu_pkg::word_t make_instr(input logic [3:0] op,
                                                  input cpu_pkg::operand_t x,
                                                  input cpu_pkg::operand_t y,
                                                  input cpu_pkg::operand_t z);
        return {op, x, y, z};
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "Word compare mismatch");
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                              input cpu_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "Address compare mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "Bit compare mismatch");
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 64; i++) begin
            check_word($sformatf("mem[%0d]", i), mem_arr[i], exp_mem[i]);
        end
    endtask

    // Holds reset and fills the image with random data
    task automatic begin_test();
        @(posedge clk);
        #5;
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rng_state   = lcg_step(rng_state);
            init_img[i] = rng_state[31:16] ^ 16'(i);
        end
    endtask

    task automatic release_reset();
        exp_mem = init_img;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt(input int limit);
        int n;
        n = 0;
        while (!status && n < limit) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!status) begin
            $display("Timeout: status did not rise within %0d cycles", limit);
            $display("Something failed");
            $fatal(1, "Timeout waiting for halt");
        end
    endtask

    task automatic test_reset_values();
        begin_test();
        init_img[8] = make_instr(`CPU_OP_STOP, direct_reg(3'd0), direct_reg(3'd0),
                                 direct_reg(3'd0));
        release_reset();
        check_bit("we", we, 1'b0);
        check_bit("status", status, 1'b0);
        check_word("out", out, 16'h0000);
        check_addr("pc", pc, 6'd8);
        wait_for_halt(1000);
        check_addr("pc", pc, 6'd9);
    endtask

    task automatic test_out_stop();
        begin_test();
        init_img[8] = make_instr(`CPU_OP_OUT, direct_reg(3'd3), direct_reg(3'd0),
                                 direct_reg(3'd0));
        init_img[9] = make_instr(`CPU_OP_STOP, direct_reg(3'd0), direct_reg(3'd0),
                                 direct_reg(3'd0));
        release_reset();
        wait_for_halt(1000);
        check_word("out", out, exp_mem[3]);
        check_addr("pc", pc, 6'd10);
        compare_memory();
    endtask

    task automatic test_arith();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        begin_test();
        init_img[8]  = make_instr(`CPU_OP_ADD, direct_reg(3'd1), direct_reg(3'd2),
                                  direct_reg(3'd4));
        init_img[9]  = make_instr(`CPU_OP_SUB, direct_reg(3'd1), direct_reg(3'd2),
                                  direct_reg(3'd5));
        init_img[10] = make_instr(`CPU_OP_MUL, direct_reg(3'd4), direct_reg(3'd5),
                                  direct_reg(3'd6));
        init_img[11] = make_instr(`CPU_OP_OUT, direct_reg(3'd6), direct_reg(3'd0),
                                  direct_reg(3'd0));
        init_img[12] = make_instr(`CPU_OP_STOP, direct_reg(3'd0), direct_reg(3'd0),
                                  direct_reg(3'd0));
        release_reset();
        a = exp_mem[1];
        b = exp_mem[2];
        exp_mem[4] = a + b;                    // Modulo 2^16
        exp_mem[5] = a - b;
        exp_mem[6] = exp_mem[4] * exp_mem[5];  // Low 16 bits of the product
        wait_for_halt(1000);
        compare_memory();
        check_word("out", out, exp_mem[6]);
        check_addr("pc", pc, 6'd13);
    endtask

    task automatic test_indirect();
        cpu_pkg::addr_t p1;
        cpu_pkg::addr_t p2;
        cpu_pkg::addr_t p7;
        begin_test();
        // Pointers sit in the low six bits, upper bits stay random
        init_img[1] = {init_img[1][15:6], 6'd40};
        init_img[2] = {init_img[2][15:6], 6'd50};
        init_img[7] = {init_img[7][15:6], 6'd60};
        init_img[8]  = make_instr(`CPU_OP_MOV, indirect_reg(3'd1), direct_reg(3'd0),
                                  indirect_reg(3'd2));
        init_img[9]  = make_instr(`CPU_OP_ADD, indirect_reg(3'd1), direct_reg(3'd3),
                                  indirect_reg(3'd7));
        init_img[10] = make_instr(`CPU_OP_SUB, direct_reg(3'd0), indirect_reg(3'd2),
                                  direct_reg(3'd6));
        init_img[11] = make_instr(`CPU_OP_STOP, direct_reg(3'd0), direct_reg(3'd0),
                                  direct_reg(3'd0));
        release_reset();
        p1 = exp_mem[1][5:0];
        p2 = exp_mem[2][5:0];
        p7 = exp_mem[7][5:0];
        exp_mem[p2] = exp_mem[p1];
        exp_mem[p7] = exp_mem[p1] + exp_mem[3];
        exp_mem[6]  = exp_mem[0] - exp_mem[p2];  // Reads the word MOV wrote
        wait_for_halt(1000);
        compare_memory();
    endtask

    task automatic test_mov_nop_stop();
        cpu_pkg::addr_t pc_hold;
        begin_test();
        init_img[8]  = make_instr(`CPU_OP_MOV, direct_reg(3'd2), direct_reg(3'd0),
                                  direct_reg(3'd5));
        // Only x is resolved, so the z address of the MOV stays behind
        init_img[9]  = make_instr(`CPU_OP_OUT, direct_reg(3'd3), direct_reg(3'd0),
                                  direct_reg(3'd0));
        init_img[10] = make_instr(4'h5, direct_reg(3'd1), direct_reg(3'd2),
                                  direct_reg(3'd3));
        init_img[11] = make_instr(4'h4, indirect_reg(3'd1), indirect_reg(3'd2),
                                  indirect_reg(3'd3));
        init_img[12] = make_instr(`CPU_OP_STOP, direct_reg(3'd0), direct_reg(3'd0),
                                  direct_reg(3'd0));
        release_reset();
        exp_mem[5] = exp_mem[2];  // No-ops leave everything else alone
        wait_for_halt(1000);
        compare_memory();
        check_word("out", out, exp_mem[3]);
        pc_hold = pc;
        repeat (50) begin
            @(posedge clk);
            #5;
            check_bit("we", we, 1'b0);
            check_addr("pc", pc, pc_hold);
        end
        check_addr("pc", pc, 6'd13);
    endtask

    initial begin
        rst_n     = 1'b0;
        rng_state = 32'hffacce96;
        test_reset_values();
        test_out_stop();
        test_arith();
        test_indirect();
        test_mov_nop_stop();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus and register widths
`define CPU_ADDR_W 6
`define CPU_DATA_W 16
`define CPU_REG_W  3

// Word address of the first instruction after reset
`define CPU_PROG_START 8

// Opcode values, instruction bits 15:12
`define CPU_OP_MOV  4'h0
`define CPU_OP_ADD  4'h1
`define CPU_OP_SUB  4'h2
`define CPU_OP_MUL  4'h3
`define CPU_OP_OUT  4'h8
`define CPU_OP_STOP 4'hF

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_DATA_W-1:0] word_t;

    // Unlisted values fall through as no-ops
    typedef enum logic [3:0] {
        OP_MOV  = `CPU_OP_MOV,
        OP_ADD  = `CPU_OP_ADD,
        OP_SUB  = `CPU_OP_SUB,
        OP_MUL  = `CPU_OP_MUL,
        OP_OUT  = `CPU_OP_OUT,
        OP_STOP = `CPU_OP_STOP
    } opcode_e;

    typedef struct packed {
        logic                  ind;  // Indirect through the register
        logic [`CPU_REG_W-1:0] rg;   // Register is memory word 0..7
    } operand_t;

    typedef struct packed {
        opcode_e  opcode;
        operand_t x;
        operand_t y;
        operand_t z;
    } instr_t;

    typedef struct packed {
        logic uses_x;
        logic uses_y;
        logic uses_z;  // Destination address, never read
    } op_use_t;

    // Resolved values of x and y, effective address of z
    typedef struct packed {
        word_t val_x;
        word_t val_y;
        addr_t ea_z;
    } operands_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    function automatic op_use_t op_use(opcode_e op);
        case (op)
            OP_MOV:                 return '{uses_x: 1'b1, uses_y: 1'b0, uses_z: 1'b1};
            OP_ADD, OP_SUB, OP_MUL: return '{uses_x: 1'b1, uses_y: 1'b1, uses_z: 1'b1};
            OP_OUT:                 return '{uses_x: 1'b1, uses_y: 1'b0, uses_z: 1'b0};
            default:                return '{uses_x: 1'b0, uses_y: 1'b0, uses_z: 1'b0};
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::mem_req_t fetch_req,
    input  wire cpu_pkg::mem_req_t resolve_req,
    input  wire cpu_pkg::mem_req_t exec_req,
    input  wire                    fetch_done,
    input  wire                    resolve_done,
    input  wire                    exec_done,
    input  wire                    halted,
    output logic                   fetch_start,
    output logic                   resolve_start,
    output logic                   exec_start,
    output logic                   we,
    output cpu_pkg::addr_t         addr,
    output cpu_pkg::word_t         data
);

    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_ADDR, S_EXEC} state_e;

    state_e            state;
    cpu_pkg::mem_req_t active;  // Request of the unit owning the bus

    always_comb begin
        case (state)
            S_FETCH: active = fetch_req;
            S_ADDR:  active = resolve_req;
            S_EXEC:  active = exec_req;
            default: active = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            fetch_start   <= 1'b0;
            resolve_start <= 1'b0;
            exec_start    <= 1'b0;
        end else begin
            fetch_start   <= 1'b0;
            resolve_start <= 1'b0;
            exec_start    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (!halted) begin  // Parked here after STOP
                        state       <= S_FETCH;
                        fetch_start <= 1'b1;
                    end
                end
                S_FETCH: begin
                    if (fetch_done) begin
                        state         <= S_ADDR;
                        resolve_start <= 1'b1;
                    end
                end
                S_ADDR: begin
                    if (resolve_done) begin
                        state      <= S_EXEC;
                        exec_start <= 1'b1;
                    end
                end
                default: begin
                    if (exec_done) begin
                        state       <= halted ? S_IDLE : S_FETCH;
                        fetch_start <= !halted;
                    end
                end
            endcase
        end
    end

    // Address holds between requests, we lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we   <= 1'b0;
            addr <= '0;
        end else begin
            we <= active.wr;
            if (active.rd || active.wr) begin
                addr <= active.addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active.wr) begin
            data <= active.wdata;
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({fetch_req.rd | fetch_req.wr,
                  resolve_req.rd | resolve_req.wr,
                  exec_req.rd | exec_req.wr}));

    a_quiet_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !(fetch_start || resolve_start || exec_start));

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire cpu_pkg::word_t  mem,
    output logic                 we,
    output cpu_pkg::addr_t       addr,
    output cpu_pkg::word_t       data,
    output cpu_pkg::word_t       out,
    output logic                 status,
    output cpu_pkg::addr_t       pc
);

    logic               fetch_start;
    logic               resolve_start;
    logic               exec_start;
    logic               fetch_done;
    logic               resolve_done;
    logic               exec_done;
    cpu_pkg::mem_req_t  fetch_req;
    cpu_pkg::mem_req_t  resolve_req;
    cpu_pkg::mem_req_t  exec_req;
    cpu_pkg::instr_t    instr;     // Held from fetch until the next fetch
    cpu_pkg::operands_t operands;

    cpu_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_req     (fetch_req),
        .resolve_req   (resolve_req),
        .exec_req      (exec_req),
        .fetch_done    (fetch_done),
        .resolve_done  (resolve_done),
        .exec_done     (exec_done),
        .halted        (status),
        .fetch_start   (fetch_start),
        .resolve_start (resolve_start),
        .exec_start    (exec_start),
        .we            (we),
        .addr          (addr),
        .data          (data)
    );

    instr_fetch u_fetch (
        .clk   (clk),
        .rst_n (rst_n),
        .start (fetch_start),
        .mem   (mem),
        .req   (fetch_req),
        .done  (fetch_done),
        .instr (instr),
        .pc    (pc)
    );

    operand_resolver u_resolve (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (resolve_start),
        .instr    (instr),
        .mem      (mem),
        .req      (resolve_req),
        .done     (resolve_done),
        .operands (operands)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (exec_start),
        .instr    (instr),
        .operands (operands),
        .req      (exec_req),
        .done     (exec_done),
        .out      (out),
        .halted   (status)  // Status port is the halt flag
    );

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none

module exec_unit (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire cpu_pkg::instr_t    instr,
    input  wire cpu_pkg::operands_t operands,
    output cpu_pkg::mem_req_t       req,
    output logic                    done,
    output cpu_pkg::word_t          out,
    output logic                    halted
);

    cpu_pkg::op_use_t use_mask;
    cpu_pkg::word_t   result;

    // Every opcode with a z operand writes it back
    assign use_mask = cpu_pkg::op_use(instr.opcode);

    always_comb begin
        case (instr.opcode)
            cpu_pkg::OP_ADD: result = operands.val_x + operands.val_y;
            cpu_pkg::OP_SUB: result = operands.val_x - operands.val_y;
            cpu_pkg::OP_MUL: result = operands.val_x * operands.val_y;  // Low half only
            default:         result = operands.val_x;                   // MOV
        endcase
    end

    // Out and halt are taken at the start edge so they show in the done cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            out    <= '0;
            halted <= 1'b0;
        end else begin
            done <= start;
            if (start && instr.opcode == cpu_pkg::OP_OUT) begin
                out <= operands.val_x;
            end
            if (start && instr.opcode == cpu_pkg::OP_STOP) begin
                halted <= 1'b1;  // Held until reset
            end
        end
    end

    always_comb begin
        req       = '0;
        req.wr    = done && use_mask.uses_z;
        req.addr  = operands.ea_z;
        req.wdata = result;
    end

    // Once stopped, nothing else reaches execute
    a_no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !req.wr);

endmodule

`default_nettype wire

//--- verilog/instr_fetch.sv
`default_nettype none

`include "cpu_params.svh"

module instr_fetch (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire cpu_pkg::word_t  mem,
    output cpu_pkg::mem_req_t    req,
    output logic                 done,
    output cpu_pkg::instr_t      instr,
    output cpu_pkg::addr_t       pc
);

    typedef enum logic [1:0] {F_IDLE, F_ISSUE, F_CAPT, F_DONE} step_e;

    step_e step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= F_IDLE;
            pc   <= cpu_pkg::addr_t'(`CPU_PROG_START);
        end else begin
            case (step)
                F_IDLE: begin
                    if (start) begin
                        step <= F_ISSUE;
                    end
                end
                F_ISSUE: step <= F_CAPT;
                F_CAPT:  step <= F_DONE;
                default: begin
                    step <= F_IDLE;
                    pc   <= pc + cpu_pkg::addr_t'(1);  // One word per instruction
                end
            endcase
        end
    end

    // Memory answers the address registered after F_ISSUE
    always_ff @(posedge clk) begin
        if (step == F_CAPT) begin
            instr <= cpu_pkg::instr_t'(mem);
        end
    end

    always_comb begin
        req      = '0;
        req.rd   = (step == F_ISSUE);
        req.addr = pc;
    end

    assign done = (step == F_DONE);

    // Sequencer waits for done before it starts another fetch
    a_fetch_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> step == F_IDLE);

endmodule

`default_nettype wire

//--- verilog/operand_resolver.sv
`default_nettype none

`include "cpu_params.svh"

module operand_resolver (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire cpu_pkg::instr_t instr,
    input  wire cpu_pkg::word_t  mem,
    output cpu_pkg::mem_req_t    req,
    output logic                 done,
    output cpu_pkg::operands_t   operands
);

    typedef enum logic [2:0] {R_IDLE, R_ISSUE, R_CAPT, R_USE, R_DONE} state_e;

    localparam logic [1:0] SEL_X   = 2'd0;
    localparam logic [1:0] SEL_Y   = 2'd1;
    localparam logic [1:0] SEL_Z   = 2'd2;
    localparam logic [1:0] SEL_END = 2'd3;

    state_e            state;
    logic [1:0]        sel;        // Operand in progress
    logic              tgt;        // Second read of an indirect x or y
    cpu_pkg::addr_t    op_addr;    // Operand address register
    cpu_pkg::word_t    cap;        // Data capture register
    cpu_pkg::op_use_t  use_mask;
    cpu_pkg::operand_t field;
    logic [1:0]        first_sel;
    logic [1:0]        next_sel;
    logic              go_tgt;
    logic              advance;

    // First used operand at or after position from
    function automatic logic [1:0] next_used(logic [1:0] from, cpu_pkg::op_use_t u);
        logic [1:0] n;
        n = SEL_END;
        if (from <= SEL_Z && u.uses_z) n = SEL_Z;
        if (from <= SEL_Y && u.uses_y) n = SEL_Y;
        if (from == SEL_X && u.uses_x) n = SEL_X;
        return n;
    endfunction

    function automatic cpu_pkg::operand_t field_of(logic [1:0] s, cpu_pkg::instr_t i);
        case (s)
            SEL_X:   return i.x;
            SEL_Y:   return i.y;
            default: return i.z;
        endcase
    endfunction

    function automatic cpu_pkg::addr_t base_addr(cpu_pkg::operand_t f);
        return {{(`CPU_ADDR_W-`CPU_REG_W){1'b0}}, f.rg};
    endfunction

    assign use_mask  = cpu_pkg::op_use(instr.opcode);
    assign field     = field_of(sel, instr);
    assign first_sel = next_used(SEL_X, use_mask);
    assign next_sel  = next_used(sel + 2'd1, use_mask);

    // z only needs its address, so it never takes the target read
    assign go_tgt  = (state == R_USE) && !tgt && field.ind && (sel != SEL_Z);
    assign advance = (state == R_USE) && !go_tgt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= R_IDLE;
            sel   <= SEL_X;
            tgt   <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (start) begin
                        tgt   <= 1'b0;
                        sel   <= first_sel;
                        state <= (first_sel == SEL_END) ? R_DONE : R_ISSUE;
                    end
                end
                R_ISSUE: state <= R_CAPT;
                R_CAPT:  state <= R_USE;
                R_USE: begin
                    if (go_tgt) begin
                        tgt   <= 1'b1;
                        state <= R_ISSUE;
                    end else begin
                        tgt   <= 1'b0;
                        sel   <= next_sel;
                        state <= (next_sel == SEL_END) ? R_DONE : R_ISSUE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && start) begin
            op_addr <= base_addr(field_of(first_sel, instr));
        end else if (go_tgt) begin
            op_addr <= cap[`CPU_ADDR_W-1:0];  // Pointer from the register
        end else if (advance) begin
            op_addr <= base_addr(field_of(next_sel, instr));
        end

        if (state == R_CAPT) begin
            cap <= mem;
        end

        if (advance) begin
            case (sel)
                SEL_X: operands.val_x <= cap;
                SEL_Y: operands.val_y <= cap;
                default: begin
                    operands.ea_z <= field.ind ? cap[`CPU_ADDR_W-1:0] : base_addr(field);
                end
            endcase
        end
    end

    always_comb begin
        req      = '0;
        req.rd   = (state == R_ISSUE);
        req.addr = op_addr;
    end

    assign done = (state == R_DONE);

    // A new start only comes after the sequencer has seen done
    a_done_not_start: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && start));

endmodule

`default_nettype wire
